// ==== design/aluPkg.sv ====
`default_nettype none

package aluPkg;

    localparam int dataWidth = 16;  // Operand and result width

    // 8-bit ALU opcodes
    typedef enum logic [7:0] {
        opAnd   = 8'h01,
        opOr    = 8'h02,
        opXor   = 8'h03,
        opAdd   = 8'h05,
        opAddu  = 8'h06,
        opSub   = 8'h09,
        opCmp   = 8'h0B,
        opMov   = 8'h0D,
        opStore = 8'h44,
        opShl1  = 8'h80,
        opShr1  = 8'h81,
        opLsh   = 8'h84,
        opLui   = 8'hF0
    } aluOp_e;

    typedef struct packed {
        logic negative;  // Bit 4
        logic zero;
        logic overflow;
        logic low;
        logic carry;     // Bit 0
    } psr_t;

endpackage

`default_nettype wire

// ==== design/execPkg.sv ====
`default_nettype none

package execPkg;

    import aluPkg::*;

    localparam int regAddrWidth = 4;
    localparam int queueDepth = 4;     // Initial instruction credits upstream
    localparam int resultCredits = 4;  // Initial result credits in the DUT
    localparam int creditWidth = $clog2(resultCredits) + 1;

    typedef struct packed {
        aluOp_e                  opcode;
        logic [regAddrWidth-1:0] dest;
        logic [regAddrWidth-1:0] srcA;
        logic [regAddrWidth-1:0] srcB;
        logic                    useImm;
        logic [7:0]              imm;     // Sign-extended into operand B
    } instr_t;

    typedef struct packed {
        aluOp_e                  opcode;
        logic [dataWidth-1:0]    operandA;
        logic [dataWidth-1:0]    operandB;
        logic [regAddrWidth-1:0] dest;
        logic                    writeEnable;
    } aluIssue_t;

    typedef struct packed {
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    value;
        psr_t                    psr;
    } result_t;

endpackage

`default_nettype wire

// ==== design/instrQueue.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrQueue import execPkg::*; (
    input  wire         clock,
    input  wire         reset,
    input  wire         instrValid,
    input  wire instr_t instr,
    input  wire         pop,
    output instr_t      headInstr,
    output logic        headValid,
    output logic        instrCredit
);

    instr_t entries [queueDepth];
    logic [$clog2(queueDepth)-1:0] readPtr;
    logic [$clog2(queueDepth)-1:0] writePtr;
    logic [$clog2(queueDepth):0]   count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
            instrCredit <= 1'b0;
        end else begin
            if (instrValid)
                writePtr <= writePtr + 1'b1;  // Sender never overruns its credits
            if (pop)
                readPtr <= readPtr + 1'b1;
            case ({instrValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            instrCredit <= pop;  // One credit back per dequeued entry
        end
    end

    always_ff @(posedge clock) begin
        if (instrValid)
            entries[writePtr] <= instr;
    end

    assign headInstr = entries[readPtr];
    assign headValid = (count != '0);

endmodule

`default_nettype wire

// ==== design/registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module registerFile import aluPkg::*; import execPkg::*; (
    input  wire                    clock,
    input  wire                    reset,
    input  wire [regAddrWidth-1:0] readAddrA,
    input  wire [regAddrWidth-1:0] readAddrB,
    input  wire                    writeEnable,
    input  wire [regAddrWidth-1:0] writeAddr,
    input  wire [dataWidth-1:0]    writeData,
    output logic [dataWidth-1:0]   readDataA,
    output logic [dataWidth-1:0]   readDataB
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++)
                regs[i] <= '0;
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Combinational reads without bypass
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu import aluPkg::*; import execPkg::*; (
    input  wire            clock,
    input  wire            reset,
    input  wire aluIssue_t issue,
    input  wire            issueValid,
    output result_t        result,
    output logic           resultValid,
    output logic           writeEnable
);

    logic [dataWidth:0]      sumFull;  // Carry-out in the top bit
    logic                    addOverflow;
    logic [regAddrWidth-1:0] resDest;
    logic [dataWidth-1:0]    resValue;
    psr_t                    psr;

    assign sumFull = {1'b0, issue.operandA} + {1'b0, issue.operandB};
    assign addOverflow = (issue.operandA[dataWidth-1] == issue.operandB[dataWidth-1])
                      && (sumFull[dataWidth-1] != issue.operandA[dataWidth-1]);

    always_ff @(posedge clock) begin
        if (!reset) begin
            resultValid <= 1'b0;
            writeEnable <= 1'b0;
            psr <= '0;
        end else begin
            resultValid <= issueValid;
            writeEnable <= issueValid && issue.writeEnable;
            if (issueValid) begin
                // Flags not touched here hold their value
                case (issue.opcode)
                    opCmp: begin
                        psr.zero <= (issue.operandA == issue.operandB);
                        psr.low <= (issue.operandB > issue.operandA);
                        psr.negative <= ($signed(issue.operandB) > $signed(issue.operandA));
                    end
                    opAdd:   psr.overflow <= addOverflow;
                    opAddu:  psr.carry <= sumFull[dataWidth];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issueValid) begin
            resDest <= issue.dest;
            case (issue.opcode)
                opAnd:   resValue <= issue.operandA & issue.operandB;
                opOr:    resValue <= issue.operandA | issue.operandB;
                opXor:   resValue <= issue.operandA ^ issue.operandB;
                opAdd,
                opAddu:  resValue <= sumFull[dataWidth-1:0];
                opSub:   resValue <= issue.operandA - issue.operandB;
                opCmp:   resValue <= '0;  // Flags only
                opMov:   resValue <= issue.operandB;
                opStore: resValue <= issue.operandA;
                opLsh:   resValue <= issue.operandA << issue.operandB[3:0];
                opShl1:  resValue <= issue.operandA << 1;
                opShr1:  resValue <= issue.operandA >> 1;
                opLui:   resValue <= {issue.operandB[7:0], 8'h00};
                default: resValue <= '0;
            endcase
        end
    end

    assign result = '{dest: resDest, value: resValue, psr: psr};

endmodule

`default_nettype wire

// ==== design/issueStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module issueStage import aluPkg::*; import execPkg::*; (
    input  wire                     clock,
    input  wire                     reset,
    input  wire instr_t             headInstr,
    input  wire                     headValid,
    input  wire [dataWidth-1:0]     readDataA,
    input  wire [dataWidth-1:0]     readDataB,
    input  wire result_t            aluResult,
    input  wire                     aluResultValid,
    input  wire                     aluWriteEnable,
    input  wire                     resultCredit,
    output logic                    pop,
    output logic [regAddrWidth-1:0] readAddrA,
    output logic [regAddrWidth-1:0] readAddrB,
    output aluIssue_t               issue,
    output logic                    issueValid
);

    logic [creditWidth-1:0] creditCount;
    logic                   fwdValid;
    logic [dataWidth-1:0]   operandA;
    logic [dataWidth-1:0]   regB;
    logic [dataWidth-1:0]   immExt;
    logic                   writesDest;

    always_ff @(posedge clock) begin
        if (!reset) begin
            creditCount <= creditWidth'(resultCredits);
        end else begin
            case ({issueValid, resultCredit})
                2'b10:   creditCount <= creditCount - 1'b1;
                2'b01:   creditCount <= creditCount + 1'b1;
                default: ;
            endcase
        end
    end

    assign readAddrA = headInstr.srcA;
    assign readAddrB = headInstr.srcB;

    // Result still in the ALU is newer than the register file
    assign fwdValid = aluResultValid && aluWriteEnable;
    assign operandA = (fwdValid && aluResult.dest == headInstr.srcA) ? aluResult.value : readDataA;
    assign regB = (fwdValid && aluResult.dest == headInstr.srcB) ? aluResult.value : readDataB;
    assign immExt = {{(dataWidth-8){headInstr.imm[7]}}, headInstr.imm};

    always_comb begin
        case (headInstr.opcode)
            opAnd, opOr, opXor, opAdd, opAddu, opSub, opMov,
            opLsh, opShl1, opShr1, opLui: writesDest = 1'b1;
            default:                      writesDest = 1'b0;  // CMP, STORE, undefined
        endcase
    end

    assign issueValid = headValid && (creditCount != '0);
    assign pop = issueValid;
    assign issue = '{opcode: headInstr.opcode,
                     operandA: operandA,
                     operandB: headInstr.useImm ? immExt : regB,
                     dest: headInstr.dest,
                     writeEnable: writesDest};

endmodule

`default_nettype wire

// ==== design/executeUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeUnit import aluPkg::*; import execPkg::*; (
    input  wire         clock,
    input  wire         reset,
    input  wire         instrValid,
    input  wire instr_t instr,
    input  wire         resultCredit,
    output logic        instrCredit,
    output logic        resultValid,
    output result_t     result
);

    instr_t                  headInstr;
    logic                    headValid;
    logic                    pop;
    logic [regAddrWidth-1:0] readAddrA;
    logic [regAddrWidth-1:0] readAddrB;
    logic [dataWidth-1:0]    readDataA;
    logic [dataWidth-1:0]    readDataB;
    aluIssue_t               issue;
    logic                    issueValid;
    logic                    writeEnable;

    instrQueue queue0 (
        .clock(clock), .reset(reset),
        .instrValid(instrValid), .instr(instr), .pop(pop),
        .headInstr(headInstr), .headValid(headValid), .instrCredit(instrCredit)
    );

    issueStage issue0 (
        .clock(clock), .reset(reset),
        .headInstr(headInstr), .headValid(headValid),
        .readDataA(readDataA), .readDataB(readDataB),
        .aluResult(result), .aluResultValid(resultValid), .aluWriteEnable(writeEnable),
        .resultCredit(resultCredit), .pop(pop),
        .readAddrA(readAddrA), .readAddrB(readAddrB),
        .issue(issue), .issueValid(issueValid)
    );

    // ALU output feeds both the write port and the result channel
    registerFile regFile0 (
        .clock(clock), .reset(reset),
        .readAddrA(readAddrA), .readAddrB(readAddrB),
        .writeEnable(writeEnable), .writeAddr(result.dest), .writeData(result.value),
        .readDataA(readDataA), .readDataB(readDataB)
    );

    alu alu0 (
        .clock(clock), .reset(reset),
        .issue(issue), .issueValid(issueValid),
        .result(result), .resultValid(resultValid), .writeEnable(writeEnable)
    );

endmodule

`default_nettype wire

// ==== tb/clockGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    initial begin
        reset = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/resultChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

module resultChecker import aluPkg::*; import execPkg::*; (
    input  wire          clock,
    input  wire          reset,
    input  wire          resultValid,
    input  wire result_t result,
    output logic         resultCredit
);

    integer seed = 32'h4a895729;
    int checkedCount = 0;
    int errorCount = 0;
    int groupErrors = 0;
    int groupCount = 0;
    int lastGroup = 0;
    int pending = 0;     // Results not yet credited back
    int holdCycles = 0;
    bit holdDone = 1'b0;

    task automatic compareField(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            errorCount++;
            groupErrors++;
        end
    endtask

    task automatic checkBeat();
        int idx;
        idx = checkedCount;
        pending++;
        if (pending > resultCredits) begin
            $display("%0t: %0d results outstanding, more than the %0d result credits",
                     $time, pending, resultCredits);
            errorCount++;
            groupErrors++;
        end
        if (idx >= executeUnitTb.numInstr) begin
            $display("%0t: extra result beat after the last stimulus line", $time);
            errorCount++;
        end else begin
            compareField("result.dest", executeUnitTb.stimInstr[idx].dest, result.dest);
            compareField("result.value", executeUnitTb.expValue[idx], result.value);
            compareField("result.psr", executeUnitTb.expPsr[idx], result.psr);
            lastGroup = executeUnitTb.expGroup[idx];
            groupCount++;
            checkedCount++;
            if (lastGroup == 5 && !holdDone) begin
                holdCycles = 16;  // Starve the issue stage of credits
                holdDone = 1'b1;
            end
            if (checkedCount == executeUnitTb.numInstr
                    || executeUnitTb.expGroup[checkedCount] != lastGroup) begin
                $display("group %0d finished: %0d results, %0d errors",
                         lastGroup, groupCount, groupErrors);
                groupCount = 0;
                groupErrors = 0;
            end
        end
    endtask

    initial begin
        resultCredit = 1'b0;
        forever begin
            @(posedge clock);
            if (!reset) begin
                resultCredit <= 1'b0;
            end else begin
                if (resultValid)
                    checkBeat();
                if (holdCycles > 0)
                    holdCycles--;
                // Prompt credit returns from group 3 on
                if (pending > 0 && holdCycles == 0
                        && (lastGroup >= 3 || ($random(seed) & 1) == 1)) begin
                    resultCredit <= 1'b1;
                    pending--;
                end else begin
                    resultCredit <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/executeUnit_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeUnitSva import execPkg::*; (
    input wire                   clock,
    input wire                   reset,
    input wire [creditWidth-1:0] creditCount,
    input wire                   issueValid,
    input wire                   resultCredit,
    input wire                   aluResultValid
);

    int failCount = 0;
    int issuedCount = 0;  // Issues since reset
    int creditsBack = 0;  // resultCredit pulses since reset

    always @(posedge clock) begin
        if (!reset) begin
            issuedCount <= 0;
            creditsBack <= 0;
        end else begin
            if (issueValid)
                issuedCount <= issuedCount + 1;
            if (resultCredit)
                creditsBack <= creditsBack + 1;
        end
    end

    creditBound: assert property (@(posedge clock) disable iff (!reset)
        creditCount <= resultCredits)
        else begin
            $error("result credit count above %0d", resultCredits);
            failCount++;
        end

    noIssueWithoutCredit: assert property (@(posedge clock) disable iff (!reset)
        issueValid |-> issuedCount - creditsBack < resultCredits)
        else begin
            $error("issue with zero result credits");
            failCount++;
        end

    resultFollowsIssue: assert property (@(posedge clock) disable iff (!reset)
        issueValid |=> aluResultValid)
        else begin
            $error("no ALU result one cycle after issue");
            failCount++;
        end

endmodule

bind issueStage executeUnitSva sva0 (
    .clock(clock), .reset(reset), .creditCount(creditCount),
    .issueValid(issueValid), .resultCredit(resultCredit),
    .aluResultValid(aluResultValid)
);

`default_nettype wire

// ==== tb/executeUnitTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeUnitTb import aluPkg::*; import execPkg::*; ();

    logic    clock;
    logic    reset;
    logic    instrValid;
    instr_t  instr;
    logic    resultCredit;
    logic    instrCredit;
    logic    resultValid;
    result_t result;

    instr_t      stimInstr [64];
    logic [15:0] expValue [64];
    psr_t        expPsr [64];
    int          expGroup [64];
    int          numInstr = 0;
    integer      seed = 32'h4a895729;
    int          sent = 0;
    int          returned = 0;  // instrCredit pulses seen
    int          accepted = 0;  // instrValid beats taken by the DUT
    int          earlyCredits = 0;
    int          tbErrors = 0;
    bit          timedOut = 1'b0;

    clockGen clockGen0 (.clock(clock), .reset(reset));

    executeUnit dut0 (
        .clock(clock), .reset(reset),
        .instrValid(instrValid), .instr(instr), .resultCredit(resultCredit),
        .instrCredit(instrCredit), .resultValid(resultValid), .result(result)
    );

    resultChecker checker0 (
        .clock(clock), .reset(reset),
        .resultValid(resultValid), .result(result), .resultCredit(resultCredit)
    );

    always @(posedge clock) begin
        if (instrValid)
            accepted <= accepted + 1;
        if (instrCredit) begin
            returned <= returned + 1;
            if (returned >= accepted) begin
                $display("%0t: instruction credit with no instruction outstanding", $time);
                earlyCredits <= earlyCredits + 1;
            end
        end
    end

    task automatic loadStim();
        int fd;
        int g, op, d, sa, sb, ui, im, v, p;
        int fields;
        logic [8*96-1:0] header;
        fd = $fopen("tb/execStim.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/execStim.txt");
            tbErrors++;
        end else begin
            void'($fgets(header, fd));  // Column legend
            while (!$feof(fd) && numInstr < 64) begin
                fields = $fscanf(fd, "%d %h %h %h %h %h %h %h %h\n",
                                 g, op, d, sa, sb, ui, im, v, p);
                if (fields == 9) begin
                    stimInstr[numInstr] = '{opcode: aluOp_e'(op[7:0]), dest: d[3:0],
                                            srcA: sa[3:0], srcB: sb[3:0],
                                            useImm: ui[0], imm: im[7:0]};
                    expValue[numInstr] = v[15:0];
                    expPsr[numInstr] = psr_t'(p[4:0]);
                    expGroup[numInstr] = g;
                    numInstr++;
                end
            end
            $fclose(fd);
        end
        if (numInstr == 0) begin
            $display("no stimulus lines were read");
            tbErrors++;
        end
    endtask

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (reset !== 1'b1 && !timedOut) begin
            @(posedge clock);
            cycles++;
            if (cycles > 40) begin
                $display("timeout: reset was never released");
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic driveAll();
        int i;
        int stall;
        bit idle;
        i = 0;
        stall = 0;
        while (i < numInstr && !timedOut) begin
            @(posedge clock);
            idle = (expGroup[i] != 4) && (($random(seed) & 3) == 0);  // No gaps in the chain
            if (!idle && sent - returned < queueDepth) begin
                instrValid <= 1'b1;
                instr <= stimInstr[i];
                sent++;
                i++;
                stall = 0;
            end else begin
                instrValid <= 1'b0;
                stall++;
                if (stall > 200) begin
                    $display("timeout: no instruction credit for 200 cycles");
                    timedOut = 1'b1;
                end
            end
        end
        @(posedge clock);
        instrValid <= 1'b0;
    endtask

    task automatic waitForDrain();
        int cycles;
        cycles = 0;
        while ((checker0.checkedCount < numInstr || returned < sent) && !timedOut) begin
            @(posedge clock);
            cycles++;
            if (cycles > 500) begin
                $display("timeout: results or instruction credits missing after 500 cycles");
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic checkCredits();
        int errs;
        errs = 0;
        if (returned != sent) begin
            $display("%0d instruction credits returned for %0d instructions", returned, sent);
            errs++;
        end
        if (earlyCredits != 0) begin
            $display("%0d instruction credits came before their instruction", earlyCredits);
            errs++;
        end
        $display("group 6 finished: %0d sent, %0d credits back, %0d errors",
                 sent, returned, errs);
        tbErrors += errs;
    endtask

    initial begin
        instrValid = 1'b0;
        instr = '0;
        loadStim();
        waitForReset();
        if (!timedOut)
            driveAll();
        if (!timedOut)
            waitForDrain();
        if (!timedOut)
            checkCredits();
        $display("checked %0d of %0d results, %0d checker errors, %0d tb errors, %0d sva fails",
                 checker0.checkedCount, numInstr, checker0.errorCount, tbErrors,
                 dut0.issue0.sva0.failCount);
        if (timedOut || checker0.errorCount != 0 || tbErrors != 0
                || dut0.issue0.sva0.failCount != 0)
            $display("STATUS: FAIL");
        else
            $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/execStim.txt ====
# group opcode dest srcA srcB useImm imm expValue expPsr (group decimal, the rest hex)
1 0D 1 0 0 1 5A 005A 00
1 0D 2 0 0 1 F0 FFF0 00
1 01 3 1 2 0 00 0050 00
1 02 4 1 2 0 00 FFFA 00
1 03 5 1 2 0 00 FFAA 00
2 0D 7 0 0 1 7F 007F 00
2 F0 8 0 0 1 7F 7F00 00
2 05 8 8 7 0 00 7F7F 00
2 05 9 8 8 0 00 FEFE 04
2 06 A 9 9 0 00 FDFC 05
2 09 B 9 7 0 00 FE7F 05
2 0B C 7 7 0 00 0000 0D
2 0B C 7 9 0 00 0000 07
2 0B C 9 7 0 00 0000 15
2 05 D 7 0 1 01 0080 11
3 84 E 1 0 1 04 05A0 11
3 80 F 2 0 0 00 FFE0 11
3 81 F F 0 0 00 7FF0 11
3 44 4 F 0 0 00 7FF0 11
3 0D 5 0 4 0 00 FFFA 11
3 0D 6 0 C 0 00 0000 11
4 0D 1 0 0 1 01 0001 11
4 05 1 1 0 1 02 0003 11
4 05 1 1 0 1 03 0006 11
4 05 1 1 1 0 00 000C 11
4 05 2 1 0 1 04 0010 11
4 05 2 2 1 0 00 001C 11
5 06 3 2 0 1 FF 001B 11
5 06 3 3 0 1 01 001C 10
5 09 4 3 2 0 00 0000 10
5 03 5 3 0 1 80 FF9C 10
5 0B 0 5 5 0 00 0000 08

// ==== flist.f ====
design/aluPkg.sv
design/execPkg.sv
design/instrQueue.sv
design/registerFile.sv
design/alu.sv
design/issueStage.sv
design/executeUnit.sv
tb/clockGen.sv
tb/resultChecker.sv
tb/executeUnit_sva.sv
tb/executeUnitTb.sv

// ==== Makefile ====
TOP := executeUnitTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f design/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log
